// File: build.f
hw/icache_pkg.sv
hw/apb_pkg.sv
hw/fetch_sequencer.sv
hw/icache_bram.sv
hw/icache_core.sv
hw/apb_inst_mem.sv
hw/icache_top.sv
tb/icache_sva.sv
tb/icache_tb.sv

// File: hw/apb_inst_mem.sv
// APB instruction memory.
// Read-only completer with rule-generated words and address-dependent wait states.

`timescale 1ns/1ps

module apb_inst_mem (
	input logic i_clock,
	input logic i_reset,
	input logic i_psel,
	input logic i_penable,
	input logic [apb_pkg::APB_ADDR_BITS-1:0] i_paddr,
	input logic i_pwrite,
	output logic [apb_pkg::APB_DATA_BITS-1:0] o_prdata,
	output logic o_pready
);
	import apb_pkg::*;

	logic [WORD_BITS-1:0] word_index;
	logic [15:0] index_ext;
	logic [WAIT_BITS-1:0] wait_target;
	logic [WAIT_BITS-1:0] wait_cnt;
	logic access;

	// Word index from bits 13 to 2.
	assign word_index = i_paddr[WORD_BITS+1:2];
	assign index_ext = 16'(word_index);

	// Wait count taken from the low index bits.
	assign wait_target = i_paddr[WAIT_BITS+1:2];

	assign access = i_psel && i_penable;
	assign o_pready = access && (wait_cnt == wait_target);

	// Writes complete but return no data.
	assign o_prdata = (o_pready && !i_pwrite) ? {index_ext ^ MEM_XOR, ~index_ext} : '0;

	always_ff @(posedge i_clock) begin
		if (i_reset)
			wait_cnt <= '0;
		else if (access && !o_pready)
			wait_cnt <= wait_cnt + 1'b1;
		else
			wait_cnt <= '0;
	end

endmodule

// File: hw/apb_pkg.sv
// APB package.
// Bus widths and the size and wait limits of the instruction memory.

package apb_pkg;

	localparam int APB_ADDR_BITS = 32;
	localparam int APB_DATA_BITS = 32;

	// Memory decodes address bits 13 to 2, upper bits alias.
	localparam int MEM_WORDS = 4096;
	localparam int WORD_BITS = $clog2(MEM_WORDS);

	// Wait states come from address bits 3 to 2.
	localparam int WAIT_MAX = 3;
	localparam int WAIT_BITS = $clog2(WAIT_MAX + 1);

	// Constant mixed into the upper half of each memory word.
	localparam logic [15:0] MEM_XOR = 16'hA5C3;

endpackage

// File: hw/fetch_sequencer.sv
// Fetch sequencer.
// Holds the program counter and hands cached instructions out over valid/ready.

`timescale 1ns/1ps

module fetch_sequencer (
	input logic i_clock,
	input logic i_reset,

	// From the cache.
	input logic i_hit,
	input logic [31:0] i_word,

	// Instruction output.
	input logic i_instr_ready,
	input logic i_redirect_valid,
	input logic [31:0] i_redirect_pc,
	output icache_pkg::fetch_addr_t o_pc,
	output logic o_instr_valid,
	output logic [31:0] o_instr,
	output logic [31:0] o_instr_pc
);
	import icache_pkg::*;

	logic transfer;

	// A hit is a valid instruction for the current PC.
	assign o_instr_valid = i_hit;
	assign o_instr = i_word;
	assign o_instr_pc = o_pc.word;

	assign transfer = i_hit && i_instr_ready;

	// PC only moves on a transfer, so a stall keeps the lookup steady.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_pc.word <= RESET_PC;
		end
		else if (transfer) begin
			if (i_redirect_valid)
				o_pc.word <= {i_redirect_pc[31:2], 2'b00};
			else
				o_pc.word <= o_pc.word + 32'd4;
		end
	end

endmodule

// File: hw/icache_bram.sv
// Cache line RAM.
// One synchronous read port and one write port, valid, tag and data per line.

`timescale 1ns/1ps

module icache_bram (
	input logic i_clock,

	// Read port.
	input logic [icache_pkg::SET_BITS-1:0] i_rd_set,
	output logic o_rd_valid,
	output logic [icache_pkg::TAG_BITS-1:0] o_rd_tag,
	output logic [31:0] o_rd_data,

	// Write port.
	input logic i_wr_enable,
	input logic [icache_pkg::SET_BITS-1:0] i_wr_set,
	input logic i_wr_valid,
	input logic [icache_pkg::TAG_BITS-1:0] i_wr_tag,
	input logic [31:0] i_wr_data
);
	import icache_pkg::*;

	logic [LINE_BITS-1:0] mem [0:SETS-1];
	logic [LINE_BITS-1:0] rd_line;

	// Read returns the old line when both ports hit the same set.
	always_ff @(posedge i_clock) begin
		if (i_wr_enable)
			mem[i_wr_set] <= {i_wr_valid, i_wr_tag, i_wr_data};
		rd_line <= mem[i_rd_set];
	end

	assign {o_rd_valid, o_rd_tag, o_rd_data} = rd_line;

endmodule

// File: hw/icache_core.sv
// Direct-mapped instruction cache.
// Clears all lines after reset, serves hits from RAM and refills misses over APB.

`timescale 1ns/1ps

module icache_core (
	input logic i_clock,
	input logic i_reset,

	// Lookup.
	input icache_pkg::fetch_addr_t i_pc,
	output logic o_hit,
	output logic [31:0] o_word,

	// APB requester.
	output logic o_psel,
	output logic o_penable,
	output logic [apb_pkg::APB_ADDR_BITS-1:0] o_paddr,
	output logic o_pwrite,
	input logic [apb_pkg::APB_DATA_BITS-1:0] i_prdata,
	input logic i_pready,

	// Statistics.
	output logic [31:0] o_hit_count,
	output logic [31:0] o_miss_count
);
	import icache_pkg::*;

	logic [1:0] state;
	fetch_addr_t miss_addr;
	logic initialized;
	logic [SET_BITS:0] clear_cnt;
	logic refilled;

	// RAM ports.
	logic [SET_BITS-1:0] rd_set;
	logic [SET_BITS-1:0] set_r;
	logic rd_fresh;
	logic rd_valid;
	logic [TAG_BITS-1:0] rd_tag;
	logic [31:0] rd_data;
	logic wr_enable;
	logic [SET_BITS-1:0] wr_set;
	logic wr_valid;
	logic [TAG_BITS-1:0] wr_tag;
	logic [31:0] wr_data;

	// Lookup results.
	logic lookup_hit;
	logic lookup_miss;
	logic refill_start;
	logic held;
	logic hold_valid;
	logic [31:0] hold_pc;
	logic [31:0] hold_word;

	icache_bram u_bram (
		.i_clock(i_clock),
		.i_rd_set(rd_set),
		.o_rd_valid(rd_valid),
		.o_rd_tag(rd_tag),
		.o_rd_data(rd_data),
		.i_wr_enable(wr_enable),
		.i_wr_set(wr_set),
		.i_wr_valid(wr_valid),
		.i_wr_tag(wr_tag),
		.i_wr_data(wr_data)
	);

	// Same PC as a hit last cycle means a stall, so replay that word.
	assign held = hold_valid && (hold_pc == i_pc.word);

	// Compare only once the RAM output belongs to this set.
	always_comb begin
		lookup_hit = 1'b0;
		lookup_miss = 1'b0;
		if (initialized && rd_fresh && !held && set_r == i_pc.field.set) begin
			if (rd_valid && rd_tag == i_pc.field.tag)
				lookup_hit = 1'b1;
			else
				lookup_miss = 1'b1;
		end
	end

	assign o_hit = lookup_hit || held;
	assign o_word = held ? hold_word : rd_data;

	// After a hit, aim the read port at the next set.
	assign rd_set = o_hit ? i_pc.field.set + 1'b1 : i_pc.field.set;
	assign refill_start = lookup_miss && state == ST_IDLE;

	assign o_psel = (state == ST_SETUP) || (state == ST_ACCESS);
	assign o_penable = state == ST_ACCESS;
	assign o_paddr = miss_addr.word;
	assign o_pwrite = 1'b0;

	// Pipeline and payload registers.
	always_ff @(posedge i_clock) begin
		set_r <= rd_set;
		rd_fresh <= !wr_enable;
		hold_pc <= i_pc.word;
		hold_word <= o_word;
		if (refill_start)
			miss_addr <= i_pc;
		if (!initialized) begin
			wr_set <= clear_cnt[SET_BITS-1:0];
			wr_valid <= 1'b0;
			wr_tag <= '0;
			wr_data <= '0;
		end
		else begin
			wr_set <= miss_addr.field.set;
			wr_valid <= 1'b1;
			wr_tag <= miss_addr.field.tag;
			wr_data <= i_prdata;
		end
	end

	// Clear sequence, refill FSM and counters.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			initialized <= 1'b0;
			clear_cnt <= '0;
			state <= ST_IDLE;
			wr_enable <= 1'b0;
			hold_valid <= 1'b0;
			refilled <= 1'b0;
			o_hit_count <= '0;
			o_miss_count <= '0;
		end
		else begin
			wr_enable <= 1'b0;
			hold_valid <= o_hit;

			// Invalidate one line per cycle.
			if (!initialized) begin
				if (!clear_cnt[SET_BITS]) begin
					wr_enable <= 1'b1;
					clear_cnt <= clear_cnt + 1'b1;
				end
				else begin
					initialized <= 1'b1;
				end
			end

			case (state)
				ST_IDLE: begin
					if (refill_start)
						state <= ST_SETUP;
				end
				ST_SETUP: state <= ST_ACCESS;
				ST_ACCESS: begin
					if (i_pready) begin
						state <= ST_WRITE;
						wr_enable <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase

			// A hit right after its own refill was already counted as a miss.
			if (refill_start) begin
				o_miss_count <= o_miss_count + 1'b1;
				refilled <= 1'b1;
			end
			else if (lookup_hit) begin
				if (!refilled)
					o_hit_count <= o_hit_count + 1'b1;
				refilled <= 1'b0;
			end
		end
	end

endmodule

// File: hw/icache_pkg.sv
// Instruction cache package.
// Cache geometry, refill FSM encodings and the fetch address word.

package icache_pkg;

	// Direct-mapped geometry, one 32-bit word per line.
	localparam int SET_BITS = 6;
	localparam int SETS = 1 << SET_BITS;
	localparam int TAG_BITS = 24;

	// Valid bit, tag and data word in one RAM entry.
	localparam int LINE_BITS = 1 + TAG_BITS + 32;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	// Refill FSM states.
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_SETUP = 2'd1;
	localparam logic [1:0] ST_ACCESS = 2'd2;
	localparam logic [1:0] ST_WRITE = 2'd3;

	// Fetch address, seen as a plain word or as lookup fields.
	typedef union packed {
		logic [31:0] word;
		struct packed {
			logic [TAG_BITS-1:0] tag;
			logic [SET_BITS-1:0] set;
			logic [1:0] offset;
		} field;
	} fetch_addr_t;

endpackage

// File: hw/icache_top.sv
// Instruction fetch top level.
// Fetch sequencer, instruction cache and APB instruction memory.

`timescale 1ns/1ps

module icache_top (
	input logic i_clock,
	input logic i_reset,
	input logic i_instr_ready,
	input logic i_redirect_valid,
	input logic [31:0] i_redirect_pc,
	output logic o_instr_valid,
	output logic [31:0] o_instr,
	output logic [31:0] o_instr_pc,
	output logic [31:0] o_hit_count,
	output logic [31:0] o_miss_count
);
	import icache_pkg::*;
	import apb_pkg::*;

	fetch_addr_t pc;
	logic hit;
	logic [31:0] word;

	// APB between cache and memory.
	logic psel;
	logic penable;
	logic [APB_ADDR_BITS-1:0] paddr;
	logic pwrite;
	logic [APB_DATA_BITS-1:0] prdata;
	logic pready;

	fetch_sequencer u_sequencer (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_hit(hit),
		.i_word(word),
		.i_instr_ready(i_instr_ready),
		.i_redirect_valid(i_redirect_valid),
		.i_redirect_pc(i_redirect_pc),
		.o_pc(pc),
		.o_instr_valid(o_instr_valid),
		.o_instr(o_instr),
		.o_instr_pc(o_instr_pc)
	);

	icache_core u_cache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(pc),
		.o_hit(hit),
		.o_word(word),
		.o_psel(psel),
		.o_penable(penable),
		.o_paddr(paddr),
		.o_pwrite(pwrite),
		.i_prdata(prdata),
		.i_pready(pready),
		.o_hit_count(o_hit_count),
		.o_miss_count(o_miss_count)
	);

	apb_inst_mem u_mem (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_psel(psel),
		.i_penable(penable),
		.i_paddr(paddr),
		.i_pwrite(pwrite),
		.o_prdata(prdata),
		.o_pready(pready)
	);

endmodule

// File: run.sh
#!/bin/sh
# Build and run the instruction fetch testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module icache_tb -f build.f -o Vicache_tb
./obj_dir/Vicache_tb | tee sim.log
if grep -q "Simulation passed" sim.log; then
	echo "run.sh: PASS"
else
	echo "run.sh: FAIL"
	exit 1
fi

// File: tb/icache_sva.sv
// Cache protocol assertions.
// Checks the APB requester, hit qualification and RAM write timing of icache_core.

`timescale 1ns/1ps

module icache_sva (
	input logic i_clock,
	input logic i_reset,
	input logic i_psel,
	input logic i_penable,
	input logic [31:0] i_paddr,
	input logic i_pready,
	input logic i_hit,
	input logic i_initialized,
	input logic i_wr_enable
);

	// Number of failed assertions.
	int fail_count = 0;

	// Select and address hold until the completer is ready.
	a_apb_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		i_psel && !i_pready |=> i_psel && $stable(i_paddr))
		else begin
			fail_count++;
			$error("APB select or address changed before PREADY");
		end

	// Access phase always follows a selected cycle.
	a_apb_setup: assert property (@(posedge i_clock) disable iff (i_reset)
		i_penable |-> $past(i_psel))
		else begin
			fail_count++;
			$error("PENABLE without PSEL in the previous cycle");
		end

	a_no_early_hit: assert property (@(posedge i_clock) disable iff (i_reset)
		!i_initialized |-> !i_hit)
		else begin
			fail_count++;
			$error("hit flagged before the clear finished");
		end

	// RAM writes either clear lines or store a completed refill.
	a_write_window: assert property (@(posedge i_clock) disable iff (i_reset)
		i_wr_enable |-> !i_initialized || $past(i_penable && i_pready))
		else begin
			fail_count++;
			$error("RAM write outside the clear or refill window");
		end

endmodule

bind icache_core icache_sva u_sva (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_psel(o_psel),
	.i_penable(o_penable),
	.i_paddr(o_paddr),
	.i_pready(i_pready),
	.i_hit(o_hit),
	.i_initialized(initialized),
	.i_wr_enable(wr_enable)
);

// File: tb/icache_tb.sv
// Instruction fetch testbench.
// Drives fetch patterns into icache_top and checks every transfer against a cache model.

`timescale 1ns/1ps

module icache_tb;

	localparam int CYCLE_LIMIT = 40000;
	localparam int CLEAR_CYCLES = 65;
	localparam logic [31:0] ALIAS_START = 32'h0000_3da8;

	logic i_clock;
	logic i_reset;
	logic i_instr_ready;
	logic i_redirect_valid;
	logic [31:0] i_redirect_pc;
	logic o_instr_valid;
	logic [31:0] o_instr;
	logic [31:0] o_instr_pc;
	logic [31:0] o_hit_count;
	logic [31:0] o_miss_count;

	int unsigned seed_state;
	int cycle_count;
	int since_reset;
	int transfer_count;
	int error_count;
	int failed_tests;
	int test_start_errors;
	string test_name;

	// Reference cache contents and the expected position in the stream.
	logic model_valid [0:63];
	logic [23:0] model_tag [0:63];
	logic [31:0] expected_pc;
	logic [31:0] model_hits;
	logic [31:0] model_misses;
	logic stalled;
	logic [31:0] stall_pc;
	logic [31:0] stall_instr;

	icache_top i_dut (.*);

	always #2 i_clock = ~i_clock;

	// Upper half is the index xor A5C3, lower half the inverted index.
	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		logic [15:0] index;
		index = {4'b0000, addr[13:2]};
		return {index ^ 16'ha5c3, ~index};
	endfunction

	function automatic logic line_present(input logic [31:0] addr);
		return model_valid[addr[7:2]] && model_tag[addr[7:2]] == addr[31:8];
	endfunction

	task automatic check_transfer();
		if (o_instr_pc !== expected_pc) begin
			$display("MISMATCH %s pc: expected %h actual %h",
				test_name, expected_pc, o_instr_pc);
			error_count++;
		end
		if (o_instr !== expected_word(expected_pc)) begin
			$display("MISMATCH %s instr at %h: expected %h actual %h",
				test_name, expected_pc, expected_word(expected_pc), o_instr);
			error_count++;
		end
		if (line_present(expected_pc)) begin
			model_hits = model_hits + 32'd1;
		end
		else begin
			model_misses = model_misses + 32'd1;
			model_valid[expected_pc[7:2]] = 1'b1;
			model_tag[expected_pc[7:2]] = expected_pc[31:8];
		end
		expected_pc = i_redirect_valid ? {i_redirect_pc[31:2], 2'b00} : expected_pc + 32'd4;
		transfer_count++;
	endtask

	// Compares every transfer and every stalled cycle.
	always @(posedge i_clock) begin
		if (i_reset) begin
			since_reset = 0;
			stalled = 1'b0;
		end
		else begin
			since_reset = since_reset + 1;
			if (o_instr_valid === 1'b1 && since_reset <= CLEAR_CYCLES) begin
				$display("ERROR %s: instruction valid %0d cycles after reset, during the clear",
					test_name, since_reset);
				error_count++;
			end
			if (stalled && (o_instr_valid !== 1'b1 || o_instr_pc !== stall_pc
					|| o_instr !== stall_instr)) begin
				$display("MISMATCH %s stalled: expected 1 %h %h actual %b %h %h", test_name,
					stall_pc, stall_instr, o_instr_valid, o_instr_pc, o_instr);
				error_count++;
			end
			stalled = 1'b0;
			if (o_instr_valid === 1'b1 && i_instr_ready) begin
				check_transfer();
			end
			else if (o_instr_valid === 1'b1) begin
				stalled = 1'b1;
				stall_pc = o_instr_pc;
				stall_instr = o_instr;
			end
		end
	end

	always @(posedge i_clock) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: run stopped after %0d cycles in test %s",
				cycle_count, test_name);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic run_transfers(input int count, input int unsigned redirect_every,
			input int unsigned stall_every);
		int target;
		target = transfer_count + count;
		while (transfer_count < target) begin
			i_instr_ready = (stall_every == 0) || ($urandom % stall_every != 0);
			i_redirect_valid = (redirect_every != 0) && ($urandom % redirect_every == 0);
			i_redirect_pc = $urandom & 32'hffff_fffc;
			@(negedge i_clock);
		end
	endtask

	// Enter a 32-word body, then jump back from its last word.
	task automatic run_loop(input logic [31:0] start, input int iterations);
		int first;
		first = transfer_count;
		while (transfer_count < first + 1 + iterations * 32) begin
			i_instr_ready = 1'b1;
			i_redirect_valid = (transfer_count == first) || (o_instr_pc == start + 32'd124);
			i_redirect_pc = start;
			@(negedge i_clock);
		end
	endtask

	task automatic check_counters();
		logic pending_hit;
		logic [31:0] hits_exp;
		logic [31:0] misses_exp;
		i_instr_ready = 1'b0;
		i_redirect_valid = 1'b0;
		while (o_instr_valid !== 1'b1)
			@(negedge i_clock);
		// The stalled next PC is counted too, once its lookup is done.
		pending_hit = line_present(expected_pc);
		hits_exp = model_hits + (pending_hit ? 32'd1 : 32'd0);
		misses_exp = model_misses + (pending_hit ? 32'd0 : 32'd1);
		@(negedge i_clock);
		if (o_hit_count !== hits_exp) begin
			$display("MISMATCH %s hit_count: expected %0d actual %0d",
				test_name, hits_exp, o_hit_count);
			error_count++;
		end
		if (o_miss_count !== misses_exp) begin
			$display("MISMATCH %s miss_count: expected %0d actual %0d",
				test_name, misses_exp, o_miss_count);
			error_count++;
		end
	endtask

	task automatic end_test();
		int errors;
		errors = error_count - test_start_errors;
		if (errors != 0)
			failed_tests++;
		$display("test %s: %0d errors, %0d transfers so far", test_name, errors, transfer_count);
		test_start_errors = error_count;
	endtask

	initial begin
		seed_state = $urandom(32'h18dc_dcb3);
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_instr_ready = 1'b0;
		i_redirect_valid = 1'b0;
		i_redirect_pc = 32'd0;
		expected_pc = 32'd0;
		model_hits = 32'd0;
		model_misses = 32'd0;
		stalled = 1'b0;
		for (int i = 0; i < 64; i++)
			model_valid[i] = 1'b0;

		test_name = "reset_clear";
		repeat (5) begin
			@(negedge i_clock);
			if (o_hit_count !== 32'd0 || o_miss_count !== 32'd0) begin
				$display("MISMATCH %s counters in reset: expected 0 0 actual %h %h",
					test_name, o_hit_count, o_miss_count);
				error_count++;
			end
		end
		i_reset = 1'b0;
		// First transfer jumps close to the 16 KiB alias point.
		while (transfer_count < 1) begin
			i_instr_ready = 1'b1;
			i_redirect_valid = 1'b1;
			i_redirect_pc = ALIAS_START;
			@(negedge i_clock);
		end
		end_test();

		test_name = "sequential";
		run_transfers(300, 0, 0);
		end_test();
		test_name = "redirect";
		run_transfers(600, 8, 0);
		end_test();
		test_name = "backpressure";
		run_transfers(500, 0, 2);
		end_test();

		test_name = "reuse_conflict";
		run_loop(32'h0000_1000, 4);
		run_loop(32'h0000_1100, 4);
		run_loop(32'h0000_1000, 2);
		check_counters();
		end_test();

		if (i_dut.u_cache.u_sva.fail_count != 0) begin
			$display("ERROR assertions: %0d cache protocol assertions failed",
				i_dut.u_cache.u_sva.fail_count);
			error_count += i_dut.u_cache.u_sva.fail_count;
		end

		$display("summary: 5 tests, %0d failed, %0d errors, %0d transfers",
			failed_tests, error_count, transfer_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
